//--- src/rv32i_pkg.sv
package rv32i_pkg;

    // data and address word
    typedef logic [31:0] rv32i_word;

    // i-type layout, loads
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // s-type layout, stores
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // funct3 occupies bits 14:12 in both views
    typedef union packed {
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } instr_u;

    // load/store width encodings
    localparam logic [2:0] f3_b  = 3'b000;
    localparam logic [2:0] f3_h  = 3'b001;
    localparam logic [2:0] f3_w  = 3'b010;
    localparam logic [2:0] f3_bu = 3'b100;
    localparam logic [2:0] f3_hu = 3'b101;

    // data memory geometry
    localparam int dmem_words     = 256;
    localparam int dmem_addr_bits = $clog2(dmem_words);

endpackage

//--- src/ctrl_pkg.sv
package ctrl_pkg;

    import rv32i_pkg::*;

    // load result selection
    typedef enum logic [2:0] {
        lw,
        lh,
        lhu,
        lb,
        lbu
    } load_sel_e;

    typedef struct packed {
        logic      mem_read;
        logic      mem_write;
        load_sel_e load_sel;
    } ctrl_t;

    // bundle held in the EX/MEM register
    typedef struct packed {
        logic      valid;
        instr_u    instruction;
        ctrl_t     ctrl;
        rv32i_word pc;
        rv32i_word alu_out;
        rv32i_word rs2_out;
    } exmem_t;

    // bundle held in the MEM/WB register
    typedef struct packed {
        logic       valid;
        logic [4:0] rd;
        rv32i_word  pc;
        rv32i_word  rdata;
        logic       misaligned;
    } memwb_t;

endpackage

//--- src/mem_stage.sv
module mem_stage
    import rv32i_pkg::*;
    import ctrl_pkg::*;
(
    input  exmem_t                    exmem,
    input  rv32i_word                 dmem_rdata,
    output logic [dmem_addr_bits-1:0] dmem_addr,
    output logic [3:0]                dmem_byte_en,
    output rv32i_word                 dmem_wdata,
    output rv32i_word                 mem_rdata,
    output logic                      misaligned
);

    logic [1:0] offset;
    logic [2:0] st_f3;
    logic       is_store;
    logic       is_access;
    logic       acc_half;
    logic       acc_word;
    logic [3:0] lane_en;
    logic [7:0] rd_byte;
    logic [15:0] rd_half;

    assign offset    = exmem.alu_out[1:0];
    assign st_f3     = exmem.instruction.s_fmt.funct3;
    assign is_store  = exmem.valid && exmem.ctrl.mem_write;
    assign is_access = exmem.valid && (exmem.ctrl.mem_read || exmem.ctrl.mem_write);

    // word index into dmem
    assign dmem_addr = exmem.alu_out[dmem_addr_bits+1:2];

    // access width: stores from funct3, loads from load_sel
    always_comb begin
        acc_half = 1'b0;
        acc_word = 1'b0;
        if (exmem.ctrl.mem_write) begin
            acc_half = (st_f3 == f3_h);
            acc_word = (st_f3 == f3_w);
        end else if (exmem.ctrl.mem_read) begin
            acc_half = (exmem.ctrl.load_sel == lh) || (exmem.ctrl.load_sel == lhu);
            acc_word = (exmem.ctrl.load_sel == lw);
        end
    end

    // halfword needs bit 0 clear, word needs bits 1:0 clear
    assign misaligned = is_access &&
                        ((acc_half && offset[0]) || (acc_word && (offset != 2'b00)));

    // store lanes before qualification
    always_comb begin
        case (st_f3)
            f3_b:    lane_en = 4'b0001 << offset;
            f3_h:    lane_en = offset[1] ? 4'b1100 : 4'b0011;
            f3_w:    lane_en = 4'b1111;
            default: lane_en = 4'b0000;
        endcase
    end

    assign dmem_byte_en = (is_store && !misaligned) ? lane_en : 4'b0000;

    // replicate store data so every lane carries it
    always_comb begin
        case (st_f3)
            f3_b:    dmem_wdata = {4{exmem.rs2_out[7:0]}};
            f3_h:    dmem_wdata = {2{exmem.rs2_out[15:0]}};
            default: dmem_wdata = exmem.rs2_out;
        endcase
    end

    // pick the addressed byte and halfword out of the read word
    always_comb begin
        case (offset)
            2'b00:   rd_byte = dmem_rdata[7:0];
            2'b01:   rd_byte = dmem_rdata[15:8];
            2'b10:   rd_byte = dmem_rdata[23:16];
            default: rd_byte = dmem_rdata[31:24];
        endcase
        rd_half = offset[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];
    end

    // extension, zero on a misaligned load
    always_comb begin
        if (misaligned) begin
            mem_rdata = '0;
        end else begin
            case (exmem.ctrl.load_sel)
                lw:      mem_rdata = dmem_rdata;
                lh:      mem_rdata = {{16{rd_half[15]}}, rd_half};
                lhu:     mem_rdata = {16'b0, rd_half};
                lb:      mem_rdata = {{24{rd_byte[7]}}, rd_byte};
                lbu:     mem_rdata = {24'b0, rd_byte};
                default: mem_rdata = dmem_rdata;
            endcase
        end
    end

endmodule

//--- src/dmem.sv
module dmem
    import rv32i_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [dmem_addr_bits-1:0] addr,
    input  logic [3:0]                byte_en,
    input  rv32i_word                 wdata,
    output rv32i_word                 rdata
);

    // word organized storage, contents undefined until written
    rv32i_word mem [dmem_words];

    // combinational read of the addressed word
    assign rdata = mem[addr];

    // byte lane writes at the rising edge
    // reset only blocks writes, the array keeps its contents
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (arst_n && byte_en[i]) begin
                mem[addr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

endmodule

//--- src/mem_pipe.sv
module mem_pipe
    import rv32i_pkg::*;
    import ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  exmem_t ex_in,
    output memwb_t wb_out
);

    exmem_t                    exmem_q;
    logic [dmem_addr_bits-1:0] dmem_addr;
    logic [3:0]                dmem_byte_en;
    rv32i_word                 dmem_wdata;
    rv32i_word                 dmem_rdata;
    rv32i_word                 mem_rdata;
    logic                      misaligned;

    // EX/MEM register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exmem_q <= '0;
        end else begin
            exmem_q <= ex_in;
        end
    end

    mem_stage mem0 (
        .exmem        (exmem_q),
        .dmem_rdata   (dmem_rdata),
        .dmem_addr    (dmem_addr),
        .dmem_byte_en (dmem_byte_en),
        .dmem_wdata   (dmem_wdata),
        .mem_rdata    (mem_rdata),
        .misaligned   (misaligned)
    );

    // store lands at the edge that moves the next op into EX/MEM
    dmem dmem0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .addr    (dmem_addr),
        .byte_en (dmem_byte_en),
        .wdata   (dmem_wdata),
        .rdata   (dmem_rdata)
    );

    // MEM/WB register, rd from the i-type view
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_out <= '0;
        end else begin
            wb_out.valid      <= exmem_q.valid;
            wb_out.rd         <= exmem_q.instruction.i_fmt.rd;
            wb_out.pc         <= exmem_q.pc;
            wb_out.rdata      <= mem_rdata;
            wb_out.misaligned <= misaligned;
        end
    end

endmodule

//--- tb/tb_clock.sv
module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period, first rising edge at 4 ns
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

//--- tb/mem_pipe_props.sv
module mem_pipe_props
    import rv32i_pkg::*;
    import ctrl_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    input exmem_t     exmem_q,
    input logic [3:0] dmem_byte_en,
    input rv32i_word  mem_rdata,
    input logic       misaligned,
    input memwb_t     wb_out
);

    timeunit 1ns;
    timeprecision 1ps;

    // only a valid store may enable a lane
    no_write_without_store: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(exmem_q.valid && exmem_q.ctrl.mem_write) |-> (dmem_byte_en == 4'b0000)
    ) else $error("byte enables active without a valid store");

    // single lane, aligned half or full word
    legal_byte_en: assert property (
        @(posedge clk) disable iff (!arst_n)
        dmem_byte_en inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                             4'b0011, 4'b1100, 4'b1111}
    ) else $error("illegal byte enable pattern %b", dmem_byte_en);

    misaligned_reads_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        misaligned |-> (mem_rdata == '0)
    ) else $error("misaligned access returned nonzero load data");

    // no writeback while held in reset
    quiet_in_reset: assert property (
        @(posedge clk) !arst_n |-> !wb_out.valid
    ) else $error("wb_out.valid high during reset");

endmodule

//--- tb/mem_pipe_tb.sv
module mem_pipe_tb
    import rv32i_pkg::*;
    import ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles = 8;

    typedef struct packed {
        logic       is_store;
        logic       valid;
        logic [2:0] f3;
        load_sel_e  sel;
        logic [9:0] addr;
        logic [4:0] rd;
        logic       mis;
        logic       sign;
    } entry_t;

    typedef struct packed {
        logic [31:0] idx;
        logic        is_load;
        rv32i_word   pc;
        logic [4:0]  rd;
        rv32i_word   rdata;
        logic        mis;
        // rising edge count at which the result should sit on wb_out
        logic [31:0] due;
    } result_t;

    logic      clk;
    logic      arst_n;
    exmem_t    ex_in;
    memwb_t    wb_out;
    entry_t    tbl[$];
    result_t   pend_q[$];
    logic [7:0] shadow [dmem_words*4];
    int        errors;
    int        checked;
    int        cycles;

    tb_clock clk0 (
        .clk (clk)
    );

    mem_pipe dut0 (
        .clk    (clk),
        .arst_n (arst_n),
        .ex_in  (ex_in),
        .wb_out (wb_out)
    );

    bind mem_pipe mem_pipe_props props0 (.*);

    task automatic add_store(input bit v, input logic [2:0] f3, input logic [9:0] a,
                             input bit mis, input bit sg);
        entry_t t;
        t = '{is_store: 1'b1, valid: v, f3: f3, sel: lw, addr: a, rd: 5'd0,
              mis: mis, sign: sg};
        tbl.push_back(t);
    endtask

    task automatic add_load(input bit v, input load_sel_e sel, input logic [9:0] a,
                            input logic [4:0] rd, input bit mis);
        entry_t t;
        t = '{is_store: 1'b0, valid: v, f3: 3'b000, sel: sel, addr: a, rd: rd,
              mis: mis, sign: 1'b0};
        tbl.push_back(t);
    endtask

    // lanes follow the store width, starting at the byte address
    function automatic void shadow_store(logic [2:0] f3, logic [9:0] a, rv32i_word data);
        int n;
        n = (f3 == f3_b) ? 1 : ((f3 == f3_h) ? 2 : 4);
        for (int k = 0; k < n; k++) begin
            shadow[a + k] = data[8*k +: 8];
        end
    endfunction

    function automatic rv32i_word load_value(load_sel_e sel, logic [9:0] a);
        rv32i_word w;
        w = {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
        case (sel)
            lh:      return {{16{w[15]}}, w[15:0]};
            lhu:     return {16'h0000, w[15:0]};
            lb:      return {{24{w[7]}}, w[7:0]};
            lbu:     return {24'h000000, w[7:0]};
            default: return w;
        endcase
    endfunction

    task automatic drive(input entry_t t, input int idx);
        exmem_t    op;
        rv32i_word data;
        result_t   r;
        op = '0;
        op.valid = t.valid;
        op.pc = 32'h0000_1000 + idx * 4;
        op.alu_out = {22'b0, t.addr};
        if (t.is_store) begin
            data = $urandom();
            if (t.sign) begin
                data = data | 32'h8080_8080;
            end
            op.instruction.s_fmt.opcode = 7'b0100011;
            op.instruction.s_fmt.funct3 = t.f3;
            op.ctrl.mem_write = 1'b1;
            op.rs2_out = data;
            if (t.valid && !t.mis) begin
                shadow_store(t.f3, t.addr, data);
            end
        end else begin
            op.instruction.i_fmt.opcode = 7'b0000011;
            op.instruction.i_fmt.rd = t.rd;
            op.ctrl.mem_read = 1'b1;
            op.ctrl.load_sel = t.sel;
        end
        ex_in = op;
        if (t.valid) begin
            r.idx = idx;
            r.is_load = !t.is_store;
            r.pc = op.pc;
            r.rd = t.rd;
            r.mis = t.mis;
            r.rdata = (t.is_store || t.mis) ? '0 : load_value(t.sel, t.addr);
            r.due = cycles + 2;
            pend_q.push_back(r);
        end else begin
            $display("test %0d: bubble at %h, no result expected", idx, t.addr);
        end
    endtask

    task automatic check_result(input result_t r);
        int bad;
        bad = 0;
        assert (cycles == r.due) else begin
            $display("test %0d result arrived at cycle %0d instead of cycle %0d",
                     r.idx, cycles, r.due);
            bad++;
        end
        assert (wb_out.pc == r.pc) else begin
            $display("FAIL wb_out.pc expected %h got %h", r.pc, wb_out.pc);
            bad++;
        end
        assert (wb_out.misaligned == r.mis) else begin
            $display("FAIL wb_out.misaligned expected %h got %h", r.mis, wb_out.misaligned);
            bad++;
        end
        if (r.is_load) begin
            assert (wb_out.rdata == r.rdata) else begin
                $display("FAIL wb_out.rdata expected %h got %h", r.rdata, wb_out.rdata);
                bad++;
            end
            assert (wb_out.rd == r.rd) else begin
                $display("FAIL wb_out.rd expected %h got %h", r.rd, wb_out.rd);
                bad++;
            end
        end
        errors += bad;
        checked++;
        $display("test %0d: %s %s", r.idx, r.is_load ? "load" : "store",
                 (bad == 0) ? "ok" : "failed");
    endtask

    // take one writeback result if one is present
    task automatic collect();
        if (wb_out.valid) begin
            assert (pend_q.size() > 0) else begin
                $display("a result appeared on wb_out with no operation pending");
                errors++;
            end
            if (pend_q.size() > 0) begin
                check_result(pend_q.pop_front());
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > tbl.size() + reset_cycles + 20) begin
            $display("timeout: results still pending after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h7071_ad47));
        arst_n = 1'b0;
        ex_in = '0;
        errors = 0;
        checked = 0;
        cycles = 0;

        // word store then load at several addresses
        add_store(1, f3_w, 10'h000, 0, 0);
        add_store(1, f3_w, 10'h044, 0, 0);
        add_store(1, f3_w, 10'h3fc, 0, 0);
        add_load(1, lw, 10'h000, 5'd1, 0);
        add_load(1, lw, 10'h044, 5'd2, 0);
        add_load(1, lw, 10'h3fc, 5'd3, 0);
        // byte lanes over a known word
        add_store(1, f3_w, 10'h080, 0, 0);
        add_store(1, f3_b, 10'h081, 0, 1);
        add_load(1, lw, 10'h080, 5'd4, 0);
        add_store(1, f3_b, 10'h080, 0, 0);
        add_store(1, f3_b, 10'h082, 0, 1);
        add_store(1, f3_b, 10'h083, 0, 0);
        add_load(1, lb, 10'h080, 5'd5, 0);
        add_load(1, lbu, 10'h080, 5'd6, 0);
        add_load(1, lb, 10'h081, 5'd7, 0);
        add_load(1, lbu, 10'h081, 5'd8, 0);
        add_load(1, lb, 10'h082, 5'd9, 0);
        add_load(1, lbu, 10'h082, 5'd10, 0);
        add_load(1, lb, 10'h083, 5'd11, 0);
        add_load(1, lbu, 10'h083, 5'd12, 0);
        // halfwords, lower one forced negative
        add_store(1, f3_h, 10'h0c0, 0, 1);
        add_store(1, f3_h, 10'h0c2, 0, 0);
        add_load(1, lh, 10'h0c0, 5'd13, 0);
        add_load(1, lhu, 10'h0c0, 5'd14, 0);
        add_load(1, lh, 10'h0c2, 5'd15, 0);
        add_load(1, lhu, 10'h0c2, 5'd16, 0);
        // misaligned accesses
        add_store(1, f3_w, 10'h0e0, 0, 0);
        add_store(1, f3_h, 10'h0e1, 1, 0);
        add_store(1, f3_w, 10'h0e2, 1, 0);
        add_store(1, f3_w, 10'h0e3, 1, 0);
        add_load(1, lw, 10'h0e0, 5'd17, 0);
        add_load(1, lh, 10'h0e3, 5'd18, 1);
        add_load(1, lhu, 10'h0e1, 5'd19, 1);
        add_load(1, lw, 10'h0e6, 5'd20, 1);
        // bubbles must not write
        add_store(1, f3_w, 10'h0f0, 0, 0);
        add_store(0, f3_w, 10'h0f0, 0, 0);
        add_load(0, lw, 10'h0f0, 5'd21, 0);
        add_load(1, lw, 10'h0f0, 5'd22, 0);

        // a valid load held on the input must not get through reset
        ex_in.valid = 1'b1;
        ex_in.ctrl.mem_read = 1'b1;
        repeat (reset_cycles) begin
            @(negedge clk);
            assert (!wb_out.valid) else begin
                $display("FAIL wb_out.valid expected 0 got %h in reset", wb_out.valid);
                errors++;
            end
        end
        arst_n = 1'b1;
        ex_in = '0;

        for (int i = 0; i < tbl.size(); i++) begin
            @(negedge clk);
            collect();
            drive(tbl[i], i);
        end
        while (pend_q.size() > 0) begin
            @(negedge clk);
            collect();
            ex_in = '0;
        end

        $display("%0d results checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- compile.f
src/rv32i_pkg.sv
src/ctrl_pkg.sv
src/mem_stage.sv
src/dmem.sv
src/mem_pipe.sv
tb/tb_clock.sv
tb/mem_pipe_props.sv
tb/mem_pipe_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the mem_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module mem_pipe_tb -Mdir obj_dir -o mem_pipe_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/mem_pipe_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
